/* design/vecmag_apb_pkg.sv */
package vecmag_apb_pkg;

    // Bus widths of the register slave
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // Master to slave
    typedef struct packed {
        logic [APB_AW-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;   // Tied high, no wait states
        logic              pslverr;
    } apb_rsp_t;

endpackage

/* design/vecmag_apb_regs.sv */
`timescale 1ns/1ps
`include "vecmag_defines.svh"

module vecmag_apb_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  vecmag_apb_pkg::apb_req_t      apb_req,
    input  logic                          busy,
    input  logic                          finish,
    input  logic [`VECMAG_RW-1:0]         result,
    output vecmag_apb_pkg::apb_rsp_t      apb_rsp,
    output logic                          start,
    output vecmag_types_pkg::vecmag_cmd_t cmd,
    output logic                          irq
);

    logic                                 access;
    logic                                 start_req;
    logic                                 start_bad;
    logic                                 addr_hit;
    logic                                 err;
    logic                                 wr_en;
    vecmag_types_pkg::vecmag_op_e         wr_op;
    logic [vecmag_apb_pkg::APB_DW-1:0]    rdata;
    logic [`VECMAG_W-1:0]                 x_q;
    logic [`VECMAG_W-1:0]                 y_q;
    vecmag_types_pkg::vecmag_op_e         op_q;
    logic                                 irqen_q;
    logic                                 done_q;
    logic [`VECMAG_RW-1:0]                res_q;

    assign access    = apb_req.psel & apb_req.penable;
    assign wr_op     = vecmag_types_pkg::vecmag_op_e'(apb_req.pwdata[`VECMAG_CTRL_OP]);
    assign start_req = apb_req.pwrite & (apb_req.paddr == `VECMAG_ADDR_CTRL)
                     & apb_req.pwdata[`VECMAG_CTRL_START];
    assign start_bad = busy | !(wr_op inside {vecmag_types_pkg::OP_MAG,
                                              vecmag_types_pkg::OP_SUMSQ,
                                              vecmag_types_pkg::OP_ISQRT});
    assign err       = access & (!addr_hit | (start_req & start_bad));
    assign wr_en     = access & apb_req.pwrite & !err;  // Errored writes are dropped

    // Read mux, also flags mapped addresses
    always_comb begin
        rdata    = '0;
        addr_hit = 1'b1;
        case (apb_req.paddr)
            `VECMAG_ADDR_CTRL: begin
                rdata[`VECMAG_CTRL_OP]    = op_q;
                rdata[`VECMAG_CTRL_IRQEN] = irqen_q;  // Start always reads 0
            end
            `VECMAG_ADDR_OPND: rdata[`VECMAG_RW-1:0] = {y_q, x_q};
            `VECMAG_ADDR_STAT: begin
                rdata[`VECMAG_STAT_BUSY] = busy;
                rdata[`VECMAG_STAT_DONE] = done_q;
            end
            `VECMAG_ADDR_RES:  rdata[`VECMAG_RW-1:0] = res_q;
            default:           addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start   <= 1'b0;
            x_q     <= '0;
            y_q     <= '0;
            op_q    <= vecmag_types_pkg::OP_MAG;
            irqen_q <= 1'b0;
            done_q  <= 1'b0;
            res_q   <= '0;
        end else begin
            start <= 1'b0;  // Single-cycle pulse
            if (wr_en) begin
                case (apb_req.paddr)
                    `VECMAG_ADDR_CTRL: begin
                        op_q    <= wr_op;
                        irqen_q <= apb_req.pwdata[`VECMAG_CTRL_IRQEN];
                        if (apb_req.pwdata[`VECMAG_CTRL_START]) begin
                            start  <= 1'b1;
                            done_q <= 1'b0;  // New command clears done
                        end
                    end
                    `VECMAG_ADDR_OPND: begin
                        x_q <= apb_req.pwdata[`VECMAG_W-1:0];
                        y_q <= apb_req.pwdata[`VECMAG_RW-1:`VECMAG_W];
                    end
                    default: ;  // STAT and RES are read-only
                endcase
            end
            if (finish) begin
                done_q <= 1'b1;  // Sticky until next start
                res_q  <= result;
            end
        end
    end

    assign cmd = '{op: op_q, y: y_q, x: x_q};

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = err;

    assign irq = done_q & irqen_q;  // Level interrupt

endmodule

/* design/vecmag_ctrl.sv */
`timescale 1ns/1ps
`include "vecmag_defines.svh"

module vecmag_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  vecmag_types_pkg::vecmag_cmd_t cmd,
    input  logic                          sq_valid,
    input  logic [`VECMAG_RW-1:0]         radicand,
    input  logic                          root_ready,
    input  logic [`VECMAG_RW-1:0]         root,
    output logic                          sq_load,
    output vecmag_types_pkg::vecmag_cmd_t sq_cmd,
    output logic                          root_start,
    output logic [`VECMAG_RW-1:0]         root_in,
    output logic                          busy,
    output logic                          finish,
    output logic [`VECMAG_RW-1:0]         result
);

    vecmag_types_pkg::vecmag_state_e state_q;
    vecmag_types_pkg::vecmag_state_e state_d;
    vecmag_types_pkg::vecmag_op_e    op_q;
    logic                            skip_root;
    logic [`VECMAG_RW-1:0]           result_q;

    assign skip_root = (op_q == vecmag_types_pkg::OP_SUMSQ);

    always_comb begin
        state_d = state_q;
        case (state_q)
            vecmag_types_pkg::ST_IDLE:
                if (start) state_d = vecmag_types_pkg::ST_SQUARE;
            vecmag_types_pkg::ST_SQUARE:
                if (sq_valid) begin
                    state_d = skip_root ? vecmag_types_pkg::ST_POST
                                        : vecmag_types_pkg::ST_ROOT;
                end
            vecmag_types_pkg::ST_ROOT:
                if (root_ready) state_d = vecmag_types_pkg::ST_POST;
            default:
                state_d = vecmag_types_pkg::ST_IDLE;  // POST lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= vecmag_types_pkg::ST_IDLE;
            op_q    <= vecmag_types_pkg::OP_MAG;
        end else begin
            state_q <= state_d;
            if (sq_load) op_q <= cmd.op;  // Held for the root decision
        end
    end

    // Result capture, from the radicand or from the root
    always_ff @(posedge clk) begin
        if (state_q == vecmag_types_pkg::ST_SQUARE && sq_valid && skip_root) begin
            result_q <= radicand;
        end else if (state_q == vecmag_types_pkg::ST_ROOT && root_ready) begin
            result_q <= root;
        end
    end

    assign sq_load    = (state_q == vecmag_types_pkg::ST_IDLE) & start;
    assign sq_cmd     = cmd;
    assign root_start = (state_q == vecmag_types_pkg::ST_SQUARE) & sq_valid & !skip_root;
    assign root_in    = radicand;
    assign busy       = (state_q != vecmag_types_pkg::ST_IDLE);
    assign finish     = (state_q == vecmag_types_pkg::ST_POST);
    assign result     = result_q;

endmodule

/* design/vecmag_isqrt.sv */
`timescale 1ns/1ps
`include "vecmag_defines.svh"

module vecmag_isqrt (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [`VECMAG_RW-1:0] radicand,
    output logic [`VECMAG_RW-1:0] root,
    output logic                  ready
);

    localparam int RW = `VECMAG_RW;
    localparam logic [RW-1:0] MASK_TOP = 1 << (RW - 2);  // Highest bit pair

    logic [RW-1:0] rem_q;
    logic [RW-1:0] res_q;
    logic [RW-1:0] mask_q;
    logic          running;
    logic [RW-1:0] cur_rem;
    logic [RW-1:0] cur_res;
    logic [RW-1:0] cur_mask;
    logic [RW-1:0] trial;
    logic [RW-1:0] nxt_rem;
    logic [RW-1:0] nxt_res;

    assign running = (mask_q != '0);

    // One shift-and-subtract step, the first one taken on start
    always_comb begin
        cur_rem  = start ? radicand : rem_q;
        cur_res  = start ? '0 : res_q;
        cur_mask = start ? MASK_TOP : mask_q;
        trial    = cur_res + cur_mask;
        if (cur_rem >= trial) begin
            nxt_rem = cur_rem - trial;
            nxt_res = (cur_res >> 1) + cur_mask;
        end else begin
            nxt_rem = cur_rem;
            nxt_res = cur_res >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (start || running) begin
            rem_q <= nxt_rem;
            res_q <= nxt_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;
            ready  <= 1'b0;
        end else begin
            if (start || running) begin
                mask_q <= cur_mask >> 2;  // Zero after the eighth step
            end
            ready <= (mask_q == RW'(1));  // Last step in progress
        end
    end

    // Root of a 16-bit radicand never exceeds 8 bits
    assign root = {{(RW - `VECMAG_W){1'b0}}, res_q[`VECMAG_W-1:0]};

endmodule

/* design/vecmag_sum_squares.sv */
`timescale 1ns/1ps
`include "vecmag_defines.svh"

module vecmag_sum_squares (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load,
    input  vecmag_types_pkg::vecmag_cmd_t cmd,
    output logic [`VECMAG_RW-1:0]         radicand,
    output logic                          valid
);

    logic [`VECMAG_RW-1:0] sq_x;
    logic [`VECMAG_RW-1:0] sq_y;
    logic [`VECMAG_RW-1:0] sum_sq;
    logic [`VECMAG_RW-1:0] packed_raw;

    assign sq_x       = cmd.x * cmd.x;
    assign sq_y       = cmd.y * cmd.y;
    assign sum_sq     = sq_x + sq_y;  // Wraps above 16 bits
    assign packed_raw = {cmd.y, cmd.x};

    // Radicand register, loaded once per command
    always_ff @(posedge clk) begin
        if (load) begin
            radicand <= (cmd.op == vecmag_types_pkg::OP_ISQRT) ? packed_raw : sum_sq;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= load;  // One cycle behind load
        end
    end

endmodule

/* design/vecmag_top.sv */
`timescale 1ns/1ps
`include "vecmag_defines.svh"

module vecmag_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  vecmag_apb_pkg::apb_req_t apb_req,
    output vecmag_apb_pkg::apb_rsp_t apb_rsp,
    output logic                     irq
);

    logic                          start;
    vecmag_types_pkg::vecmag_cmd_t cmd;
    logic                          busy;
    logic                          finish;
    logic [`VECMAG_RW-1:0]         result;
    logic                          sq_load;
    vecmag_types_pkg::vecmag_cmd_t sq_cmd;
    logic                          sq_valid;
    logic [`VECMAG_RW-1:0]         radicand;
    logic                          root_start;
    logic [`VECMAG_RW-1:0]         root_in;
    logic                          root_ready;
    logic [`VECMAG_RW-1:0]         root;

    vecmag_apb_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .busy    (busy),
        .finish  (finish),
        .result  (result),
        .apb_rsp (apb_rsp),
        .start   (start),
        .cmd     (cmd),
        .irq     (irq)
    );

    vecmag_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cmd        (cmd),
        .sq_valid   (sq_valid),
        .radicand   (radicand),
        .root_ready (root_ready),
        .root       (root),
        .sq_load    (sq_load),
        .sq_cmd     (sq_cmd),
        .root_start (root_start),
        .root_in    (root_in),
        .busy       (busy),
        .finish     (finish),
        .result     (result)
    );

    vecmag_sum_squares u_sumsq (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (sq_load),
        .cmd      (sq_cmd),
        .radicand (radicand),
        .valid    (sq_valid)
    );

    vecmag_isqrt u_isqrt (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (root_start),
        .radicand (root_in),
        .root     (root),
        .ready    (root_ready)
    );

endmodule

/* design/vecmag_types_pkg.sv */
`include "vecmag_defines.svh"

package vecmag_types_pkg;

    // Command opcodes, encoding 3 is refused by the register block
    typedef enum logic [1:0] {
        OP_MAG   = 2'd0,  // Floor of sqrt(x*x + y*y)
        OP_SUMSQ = 2'd1,  // x*x + y*y only
        OP_ISQRT = 2'd2   // Floor sqrt of {y, x}
    } vecmag_op_e;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SQUARE = 2'd1,
        ST_ROOT   = 2'd2,
        ST_POST   = 2'd3
    } vecmag_state_e;

    // Command handed from the register block to the controller
    typedef struct packed {
        vecmag_op_e              op;
        logic [`VECMAG_W-1:0]    y;   // High byte of a raw operand
        logic [`VECMAG_W-1:0]    x;   // Low byte of a raw operand
    } vecmag_cmd_t;

endpackage

/* include/vecmag_defines.svh */
`ifndef VECMAG_DEFINES_SVH
`define VECMAG_DEFINES_SVH

// Operand width, one byte per coordinate
`define VECMAG_W 8

// Radicand and result width
`define VECMAG_RW (2 * `VECMAG_W)

// APB register map
`define VECMAG_ADDR_CTRL 8'h00
`define VECMAG_ADDR_OPND 8'h04
`define VECMAG_ADDR_STAT 8'h08
`define VECMAG_ADDR_RES  8'h0C

// CTRL register fields
`define VECMAG_CTRL_START 0
`define VECMAG_CTRL_OP    2:1
`define VECMAG_CTRL_IRQEN 3

// STAT register fields
`define VECMAG_STAT_BUSY 0
`define VECMAG_STAT_DONE 1

`endif

/* sim/vecmag_properties.sv */
`timescale 1ns/1ps

module vecmag_properties (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic finish,
    input logic start,
    input logic sq_load,
    input logic root_start
);

    // Finish marks the last busy cycle
    finish_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        finish |-> busy ##1 !busy)
        else $error("finish pulsed outside the last busy cycle");

    // Radicand register is valid one cycle after the load
    root_after_square: assert property (@(posedge clk) disable iff (!rst_n)
        root_start |-> $past(sq_load))
        else $error("root engine started without a valid radicand");

    // Register block refuses starts while busy
    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("start pulsed while a command was in flight");

endmodule

bind vecmag_ctrl vecmag_properties u_ctrl_props (
    .clk(clk), .rst_n(rst_n), .busy(busy), .finish(finish), .start(start),
    .sq_load(sq_load), .root_start(root_start)
);

/* sim/vecmag_stimulus.txt */
# op x y irqen expected, all hex
# op 0 magnitude, 1 sum of squares, 2 root of {y,x}, 3 refused (RES unchanged)
0 00 00 1 0000
0 03 04 1 0005
0 ff ff 0 00fd
0 ff 00 1 00ff
0 00 ff 0 00ff
0 05 0c 1 000d
0 08 0f 0 0011
0 01 01 1 0001
0 0a 0a 0 000e
0 64 64 1 008d
0 b4 b4 0 00fe
0 c8 32 1 00ce
0 14 15 0 001d
0 07 18 1 0019
1 03 04 1 0019
1 00 00 0 0000
1 ff 00 1 fe01
1 0c 05 0 00a9
1 64 64 1 4e20
1 ff ff 0 fc02
1 b4 b4 1 fd20
1 10 20 0 0500
3 ff ff 1 0500
1 01 01 1 0002
2 ff ff 1 00ff
2 00 00 0 0000
2 10 00 1 0004
2 00 01 0 0010
2 ff 00 1 000f
2 00 40 0 0080
2 01 90 1 00c0
2 00 90 0 00c0
2 ff 8f 1 00bf
2 39 05 1 0024
3 01 02 1 0024
2 90 00 0 000c
0 00 00 0 0000

/* sim/vecmag_tb.sv */
`timescale 1ns/1ps
`include "vecmag_defines.svh"

module vecmag_tb;

    localparam int CLK_HALF   = 20;
    localparam int POLL_LIMIT = 100;  // STAT reads before giving up

    logic                     clk;
    logic                     rst_n;
    vecmag_apb_pkg::apb_req_t apb_req;
    vecmag_apb_pkg::apb_rsp_t apb_rsp;
    logic                     irq;

    int          errors;
    int          checks;
    int          tests;
    logic        timed_out;
    logic [31:0] lcg_state;

    vecmag_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Largest r with r*r <= v
    function automatic int unsigned ref_isqrt(input int unsigned v);
        int unsigned r;
        r = 0;
        while ((r + 1) * (r + 1) <= v) begin
            r++;
        end
        return r;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [1:0] op, input logic irqen);
        logic [31:0] w;
        w                     = '0;
        w[`VECMAG_CTRL_START] = 1'b1;
        w[`VECMAG_CTRL_OP]    = op;
        w[`VECMAG_CTRL_IRQEN] = irqen;
        return w;
    endfunction

    // Setup phase, access phase, response sampled mid access
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check("pready", apb_rsp.pready, 1'b1);
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_done(output logic [31:0] stat);
        int   polls;
        logic err;
        polls = 0;
        stat  = '0;
        while (!stat[`VECMAG_STAT_DONE] && polls < POLL_LIMIT) begin
            apb_read(`VECMAG_ADDR_STAT, stat, err);
            polls++;
        end
        if (!stat[`VECMAG_STAT_DONE]) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: done bit not set after %0d status reads", POLL_LIMIT);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic execute_command(input logic [1:0] op, input logic [7:0] x,
                                   input logic [7:0] y, input logic irqen,
                                   input logic [15:0] expected);
        logic [31:0] rdata;
        logic        err;
        int          errs_before;
        errs_before = errors;
        apb_write(`VECMAG_ADDR_OPND, {16'h0, y, x}, err);
        check("pslverr", err, 1'b0);
        apb_write(`VECMAG_ADDR_CTRL, ctrl_word(op, irqen), err);
        if (op == 2'd3) begin
            check("pslverr", err, 1'b1);  // Illegal opcode refused
        end else begin
            check("pslverr", err, 1'b0);
            @(negedge clk);
            check("irq", irq, 1'b0);  // Start clears done
            wait_done(rdata);
            check("stat.busy", rdata[`VECMAG_STAT_BUSY], 1'b0);
            @(negedge clk);
            check("irq", irq, irqen);
        end
        apb_read(`VECMAG_ADDR_RES, rdata, err);
        check("res", rdata, {16'h0, expected});
        report_test($sformatf("op %0d x 0x%h y 0x%h", op, x, y), errs_before);
    endtask

    task automatic file_tests();
        int           fd;
        logic [767:0] line;
        logic [31:0]  op;
        logic [31:0]  x;
        logic [31:0]  y;
        logic [31:0]  irqen;
        logic [31:0]  expected;
        fd = $fopen("sim/vecmag_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file sim/vecmag_stimulus.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = '0;
                if ($fgets(line, fd) > 0 &&
                    $sscanf(line, "%h %h %h %h %h", op, x, y, irqen, expected) == 5) begin
                    execute_command(op[1:0], x[7:0], y[7:0], irqen[0], expected[15:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    // Second start lands while the first command runs
    task automatic refuse_while_busy(input logic [15:0] expected);
        logic [31:0] rdata;
        logic        err;
        int          errs_before;
        errs_before = errors;
        apb_write(`VECMAG_ADDR_OPND, 32'h0000_0403, err);
        apb_write(`VECMAG_ADDR_CTRL, ctrl_word(vecmag_types_pkg::OP_MAG, 1'b1), err);
        check("pslverr", err, 1'b0);
        apb_write(`VECMAG_ADDR_CTRL, ctrl_word(vecmag_types_pkg::OP_SUMSQ, 1'b0), err);
        check("pslverr", err, 1'b1);
        wait_done(rdata);
        apb_read(`VECMAG_ADDR_CTRL, rdata, err);
        check("ctrl.op", rdata[`VECMAG_CTRL_OP], vecmag_types_pkg::OP_MAG);
        check("ctrl.irqen", rdata[`VECMAG_CTRL_IRQEN], 1'b1);
        apb_read(`VECMAG_ADDR_RES, rdata, err);
        check("res", rdata, {16'h0, expected});
        report_test("start while busy", errs_before);
    endtask

    task automatic read_unmapped(input logic [15:0] expected);
        logic [31:0] rdata;
        logic        err;
        int          errs_before;
        errs_before = errors;
        apb_read(8'h10, rdata, err);
        check("pslverr", err, 1'b1);
        apb_read(`VECMAG_ADDR_RES, rdata, err);
        check("res", rdata, {16'h0, expected});
        report_test("unmapped address", errs_before);
    endtask

    task automatic random_magnitudes(input int count);
        logic [31:0] r;
        int unsigned xi;
        int unsigned yi;
        logic [15:0] expected;
        for (int i = 0; i < count && !timed_out; i++) begin
            r        = lcg_next();
            xi       = r[23:16];
            yi       = r[31:24];
            expected = ref_isqrt((xi * xi + yi * yi) % 65536);  // 16-bit radicand register
            execute_command(vecmag_types_pkg::OP_MAG, xi[7:0], yi[7:0], r[13], expected);
        end
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        lcg_state = 32'd69076;
        apb_req   = '0;
        rst_n     = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("irq", irq, 1'b0);
        file_tests();
        if (!timed_out) refuse_while_busy(ref_isqrt(3 * 3 + 4 * 4));
        if (!timed_out) read_unmapped(ref_isqrt(3 * 3 + 4 * 4));
        if (!timed_out) random_magnitudes(50);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* vecmag.f */
+incdir+include
design/vecmag_types_pkg.sv
design/vecmag_apb_pkg.sv
design/vecmag_apb_regs.sv
design/vecmag_ctrl.sv
design/vecmag_sum_squares.sv
design/vecmag_isqrt.sv
design/vecmag_top.sv
sim/vecmag_properties.sv
sim/vecmag_tb.sv
